// ==== design/ccu_pkg.sv ====
package ccu_pkg;

  // Register port widths
  localparam int REG_ADDR_W = 4;
  localparam int REG_DATA_W = 32;

  // Control states, the encoding shows up in STATUS
  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    START       = 3'd1,
    OPERATE     = 3'd2,
    DONE        = 3'd3,
    FAULT       = 3'd4,
    INTERRUPTED = 3'd5
  } ccu_state_e;

  // Host register map
  typedef enum logic [REG_ADDR_W-1:0] {
    DATA_SIZE     = 4'd0,
    GRID_SIZE     = 4'd1,
    SCLE_SIZE     = 4'd2,
    RSLT_SIZE     = 4'd3,
    PCKT_SIZE     = 4'd4,
    LOADED        = 4'd5,
    CONTROL       = 4'd6,
    STATUS        = 4'd7,
    PROGRESS_RSLT = 4'd8,
    PROGRESS_ITER = 4'd9,
    FAULT_MASK    = 4'd10
  } ccu_reg_addr_e;

  // LOADED fields
  localparam int LD_DATA = 0;
  localparam int LD_GRID = 1;
  localparam int LD_SCLE = 2;
  localparam int LD_WGHT = 3;
  localparam int LD_RSLT = 4;

  // CONTROL command bits, write only
  localparam int CTL_START = 0;
  localparam int CTL_SOFT  = 1;
  localparam int CTL_ABORT = 2;
  localparam int CTL_ERROR = 3;
  localparam int CTL_CLEAR = 4;

  // STATUS fields
  localparam int ST_IDLE      = 0;
  localparam int ST_BUSY      = 1;
  localparam int ST_ERROR     = 2;
  localparam int ST_LOCKED    = 3;
  localparam int ST_VALID     = 4;
  localparam int ST_STATE_LSB = 5;
  localparam int ST_STATE_MSB = 7;

endpackage

// ==== design/ccu_cfg_if.sv ====
`timescale 1ns/10ps

interface ccu_cfg_if;

  // Problem sizes as written by the host
  logic [ccu_pkg::REG_DATA_W-1:0] data_size;
  logic [ccu_pkg::REG_DATA_W-1:0] grid_size;
  logic [ccu_pkg::REG_DATA_W-1:0] scle_size;
  logic [ccu_pkg::REG_DATA_W-1:0] rslt_size;
  logic [ccu_pkg::REG_DATA_W-1:0] pckt_size;

  logic data_loaded;
  logic grid_loaded;
  logic scle_loaded;
  logic wght_loaded;
  logic rslt_loaded;

  // Single-cycle host commands
  logic start_req;
  logic soft_req;
  logic abort_req;
  logic error_req;
  logic clear_req;

  // Status returned by the control FSM
  ccu_pkg::ccu_state_e state;
  logic cfg_valid;
  logic locked;

  modport regs (
    output data_size, grid_size, scle_size, rslt_size, pckt_size,
    output data_loaded, grid_loaded, scle_loaded, wght_loaded, rslt_loaded,
    output start_req, soft_req, abort_req, error_req, clear_req,
    input  state, cfg_valid, locked
  );

  modport ctrl (
    input  data_size, grid_size, scle_size, rslt_size, pckt_size,
    input  data_loaded, grid_loaded, scle_loaded, wght_loaded, rslt_loaded,
    input  start_req, soft_req, abort_req, error_req, clear_req,
    output state, cfg_valid, locked
  );

endinterface

// ==== design/ccu_progress_if.sv ====
`timescale 1ns/10ps

interface ccu_progress_if;

  // FSM side
  logic        load;
  logic        advance;
  logic [31:0] total;

  // Tracker side
  logic        last_iter;
  logic [31:0] results_exported;
  logic [31:0] iteration;

  modport ctrl (
    output load,
    output advance,
    output total,
    input  last_iter
  );

  modport track (
    input  load,
    input  advance,
    input  total,
    output last_iter,
    output results_exported,
    output iteration
  );

endinterface

// ==== design/ccu_reg_file.sv ====
`timescale 1ns/10ps

module ccu_reg_file #(
  parameter int NUM_PERIPHERALS = 3
) (
  input  logic                           fsm_clk,
  input  logic                           rst,
  input  logic                           reg_wr_en,
  input  logic                           reg_rd_en,
  input  logic [ccu_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [ccu_pkg::REG_DATA_W-1:0] reg_wdata,
  input  logic [31:0]                    results_exported,
  input  logic [31:0]                    iteration,
  input  logic [NUM_PERIPHERALS-1:0]     fault_mask,
  output logic [ccu_pkg::REG_DATA_W-1:0] reg_rdata,
  output logic                           reg_rvalid,
  ccu_cfg_if.regs                        cfg
);

  ccu_pkg::ccu_reg_addr_e         addr;
  logic                           ctl_write;
  logic [ccu_pkg::REG_DATA_W-1:0] status_word;
  logic [ccu_pkg::REG_DATA_W-1:0] rd_data;

  assign addr      = ccu_pkg::ccu_reg_addr_e'(reg_addr);
  assign ctl_write = reg_wr_en && (addr == ccu_pkg::CONTROL);

  // Configuration registers
  always_ff @(posedge fsm_clk) begin
    if (rst) begin
      cfg.data_size   <= '0;
      cfg.grid_size   <= '0;
      cfg.scle_size   <= '0;
      cfg.rslt_size   <= '0;
      cfg.pckt_size   <= '0;
      cfg.data_loaded <= 1'b0;
      cfg.grid_loaded <= 1'b0;
      cfg.scle_loaded <= 1'b0;
      cfg.wght_loaded <= 1'b0;
      cfg.rslt_loaded <= 1'b0;
    end else if (reg_wr_en) begin
      case (addr)
        ccu_pkg::DATA_SIZE: cfg.data_size <= reg_wdata;
        ccu_pkg::GRID_SIZE: cfg.grid_size <= reg_wdata;
        ccu_pkg::SCLE_SIZE: cfg.scle_size <= reg_wdata;
        ccu_pkg::RSLT_SIZE: cfg.rslt_size <= reg_wdata;
        ccu_pkg::PCKT_SIZE: cfg.pckt_size <= reg_wdata;
        ccu_pkg::LOADED: begin
          cfg.data_loaded <= reg_wdata[ccu_pkg::LD_DATA];
          cfg.grid_loaded <= reg_wdata[ccu_pkg::LD_GRID];
          cfg.scle_loaded <= reg_wdata[ccu_pkg::LD_SCLE];
          cfg.wght_loaded <= reg_wdata[ccu_pkg::LD_WGHT];
          cfg.rslt_loaded <= reg_wdata[ccu_pkg::LD_RSLT];
        end
        default: ;
      endcase
    end
  end

  // CONTROL bits become pulses one cycle after the write
  always_ff @(posedge fsm_clk) begin
    if (rst) begin
      cfg.start_req <= 1'b0;
      cfg.soft_req  <= 1'b0;
      cfg.abort_req <= 1'b0;
      cfg.error_req <= 1'b0;
      cfg.clear_req <= 1'b0;
    end else begin
      cfg.start_req <= ctl_write && reg_wdata[ccu_pkg::CTL_START];
      cfg.soft_req  <= ctl_write && reg_wdata[ccu_pkg::CTL_SOFT];
      cfg.abort_req <= ctl_write && reg_wdata[ccu_pkg::CTL_ABORT];
      cfg.error_req <= ctl_write && reg_wdata[ccu_pkg::CTL_ERROR];
      cfg.clear_req <= ctl_write && reg_wdata[ccu_pkg::CTL_CLEAR];
    end
  end

  always_comb begin
    status_word = '0;
    status_word[ccu_pkg::ST_IDLE]   = (cfg.state == ccu_pkg::IDLE);
    status_word[ccu_pkg::ST_BUSY]   = (cfg.state == ccu_pkg::START) ||
                                      (cfg.state == ccu_pkg::OPERATE);
    status_word[ccu_pkg::ST_ERROR]  = (cfg.state == ccu_pkg::FAULT);
    status_word[ccu_pkg::ST_LOCKED] = cfg.locked;
    status_word[ccu_pkg::ST_VALID]  = cfg.cfg_valid;
    status_word[ccu_pkg::ST_STATE_MSB:ccu_pkg::ST_STATE_LSB] = cfg.state;
  end

  // Read multiplexer, CONTROL and unmapped addresses read as zero
  always_comb begin
    rd_data = '0;
    case (addr)
      ccu_pkg::DATA_SIZE:     rd_data = cfg.data_size;
      ccu_pkg::GRID_SIZE:     rd_data = cfg.grid_size;
      ccu_pkg::SCLE_SIZE:     rd_data = cfg.scle_size;
      ccu_pkg::RSLT_SIZE:     rd_data = cfg.rslt_size;
      ccu_pkg::PCKT_SIZE:     rd_data = cfg.pckt_size;
      ccu_pkg::LOADED: begin
        rd_data[ccu_pkg::LD_DATA] = cfg.data_loaded;
        rd_data[ccu_pkg::LD_GRID] = cfg.grid_loaded;
        rd_data[ccu_pkg::LD_SCLE] = cfg.scle_loaded;
        rd_data[ccu_pkg::LD_WGHT] = cfg.wght_loaded;
        rd_data[ccu_pkg::LD_RSLT] = cfg.rslt_loaded;
      end
      ccu_pkg::STATUS:        rd_data = status_word;
      ccu_pkg::PROGRESS_RSLT: rd_data = results_exported;
      ccu_pkg::PROGRESS_ITER: rd_data = iteration;
      ccu_pkg::FAULT_MASK:    rd_data[NUM_PERIPHERALS-1:0] = fault_mask;
      default: ;
    endcase
  end

  // Fixed read latency of one cycle
  always_ff @(posedge fsm_clk) begin
    if (rst) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_rd_en;
    end
  end

  always_ff @(posedge fsm_clk) begin
    if (reg_rd_en) begin
      reg_rdata <= rd_data;
    end
  end

endmodule

// ==== design/ccu_result_tracker.sv ====
`timescale 1ns/10ps

module ccu_result_tracker #(
  parameter int RSLT_CHANNELS = 4
) (
  input  logic                     fsm_clk,
  input  logic                     rst,
  ccu_progress_if.track            prog,
  output logic [RSLT_CHANNELS-1:0] use_channels
);

  logic [31:0] remaining;
  logic [31:0] exported;
  logic [31:0] iteration;
  logic [31:0] iter_size;

  // Results handed out this iteration
  assign iter_size = (remaining > RSLT_CHANNELS) ? 32'(RSLT_CHANNELS) : remaining;

  assign prog.last_iter        = (remaining <= RSLT_CHANNELS);
  assign prog.results_exported = exported;
  assign prog.iteration        = iteration;

  // Low channels first, all zero once nothing remains
  always_comb begin
    for (int ch = 0; ch < RSLT_CHANNELS; ch++) begin
      use_channels[ch] = (32'(ch) < iter_size);
    end
  end

  always_ff @(posedge fsm_clk) begin
    if (rst) begin
      remaining <= '0;
      exported  <= '0;
      iteration <= '0;
    end else if (prog.load) begin
      remaining <= prog.total;
      exported  <= '0;
      iteration <= '0;
    end else if (prog.advance) begin
      remaining <= remaining - iter_size;
      exported  <= exported + iter_size;
      iteration <= iteration + 32'd1;
    end
  end

endmodule

// ==== design/ccu_fault_monitor.sv ====
`timescale 1ns/10ps

module ccu_fault_monitor #(
  parameter int NUM_PERIPHERALS = 3
) (
  input  logic                       fsm_clk,
  input  logic                       rst,
  input  logic [NUM_PERIPHERALS-1:0] peripheral_error,
  input  logic                       clear,
  output logic                       fault,
  output logic [NUM_PERIPHERALS-1:0] fault_mask
);

  // Two flops per line, the error inputs come from other clock domains
  logic [NUM_PERIPHERALS-1:0] sync_q1;
  logic [NUM_PERIPHERALS-1:0] sync_q2;

  always_ff @(posedge fsm_clk) begin
    if (rst) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= peripheral_error;
      sync_q2 <= sync_q1;
    end
  end

  // Sticky mask, a short error pulse is not lost
  always_ff @(posedge fsm_clk) begin
    if (rst || clear) begin
      fault_mask <= '0;
    end else begin
      fault_mask <= fault_mask | sync_q2;
    end
  end

  assign fault = |fault_mask;

endmodule

// ==== design/ccu_fsm.sv ====
`timescale 1ns/10ps

module ccu_fsm #(
  parameter int DATA_ADDR_W = 16,
  parameter int GRID_ADDR_W = 8,
  parameter int SCLE_ADDR_W = 8,
  localparam int PCKT_ADDR_W = DATA_ADDR_W + GRID_ADDR_W - 1
) (
  input  logic                   fsm_clk,
  input  logic                   rst,
  input  logic                   rslt_tlast,
  input  logic                   fault,
  ccu_cfg_if.ctrl                cfg,
  ccu_progress_if.ctrl           prog,
  output logic                   operation_start,
  output logic [DATA_ADDR_W:0]   data_size,
  output logic [GRID_ADDR_W:0]   grid_size,
  output logic [SCLE_ADDR_W:0]   scle_size,
  output logic [PCKT_ADDR_W:0]   pckt_size,
  output logic                   operation_busy,
  output logic                   operation_complete,
  output logic                   operation_error,
  output logic                   locked,
  output logic                   pl2ps_intr,
  output logic                   monitor_clear
);

  localparam logic [63:0] MAX_DATA_SIZE = 64'd1 << DATA_ADDR_W;
  localparam logic [63:0] MAX_GRID_SIZE = 64'd1 << GRID_ADDR_W;
  localparam logic [63:0] MAX_SCLE_SIZE = 64'd1 << SCLE_ADDR_W;
  localparam logic [63:0] MAX_PCKT_SIZE = 64'd1 << PCKT_ADDR_W;

  ccu_pkg::ccu_state_e state;
  ccu_pkg::ccu_state_e state_next;
  logic                soft_pending;
  logic                in_start;
  logic                in_operate;
  logic                intr_entry;

  assign in_start   = (state == ccu_pkg::START);
  assign in_operate = (state == ccu_pkg::OPERATE);

  // Every input loaded and every size nonzero and within range
  assign cfg.cfg_valid = &{
    cfg.data_loaded, cfg.grid_loaded, cfg.scle_loaded, cfg.wght_loaded,
    |cfg.data_size, |cfg.grid_size, |cfg.scle_size, |cfg.pckt_size, |cfg.rslt_size,
    64'(cfg.data_size) <= MAX_DATA_SIZE,
    64'(cfg.grid_size) <= MAX_GRID_SIZE,
    64'(cfg.scle_size) <= MAX_SCLE_SIZE,
    64'(cfg.pckt_size) <= MAX_PCKT_SIZE
  };

  always_comb begin
    state_next = state;
    case (state)
      ccu_pkg::IDLE: begin
        if (cfg.start_req && cfg.cfg_valid) begin
          state_next = ccu_pkg::START;
        end else if (cfg.start_req) begin
          state_next = ccu_pkg::FAULT;
        end
      end
      ccu_pkg::START: state_next = ccu_pkg::OPERATE;
      ccu_pkg::OPERATE: begin
        // A held soft request wins over the normal end of the run
        if (rslt_tlast && soft_pending) begin
          state_next = ccu_pkg::INTERRUPTED;
        end else if (rslt_tlast && prog.last_iter) begin
          state_next = ccu_pkg::DONE;
        end
      end
      ccu_pkg::DONE: begin
        if (!cfg.rslt_loaded) begin
          state_next = ccu_pkg::IDLE;
        end
      end
      ccu_pkg::FAULT, ccu_pkg::INTERRUPTED: begin
        if (cfg.clear_req) begin
          state_next = ccu_pkg::IDLE;
        end
      end
      default: state_next = ccu_pkg::IDLE;
    endcase
    // Mask is stale until START clears it, so only a running operation faults
    if (fault && in_operate) begin
      state_next = ccu_pkg::FAULT;
    end
    if (cfg.abort_req || cfg.error_req) begin
      state_next = ccu_pkg::INTERRUPTED;
    end
  end

  assign intr_entry = (state_next != state) &&
                      (state_next inside {ccu_pkg::DONE, ccu_pkg::FAULT, ccu_pkg::INTERRUPTED});

  always_ff @(posedge fsm_clk) begin
    if (rst) begin
      state        <= ccu_pkg::IDLE;
      soft_pending <= 1'b0;
      pl2ps_intr   <= 1'b0;
    end else begin
      state        <= state_next;
      soft_pending <= (in_start || in_operate) && (soft_pending || cfg.soft_req);
      pl2ps_intr   <= intr_entry;
    end
  end

  // Sizes are only presented alongside operation_start
  assign data_size = in_start ? cfg.data_size[DATA_ADDR_W:0] : '0;
  assign grid_size = in_start ? cfg.grid_size[GRID_ADDR_W:0] : '0;
  assign scle_size = in_start ? cfg.scle_size[SCLE_ADDR_W:0] : '0;
  assign pckt_size = in_start ? cfg.pckt_size[PCKT_ADDR_W:0] : '0;

  assign operation_start    = in_start;
  assign operation_busy     = in_start || in_operate;
  assign operation_complete = (state == ccu_pkg::DONE);
  assign operation_error    = (state == ccu_pkg::FAULT);
  assign locked             = (state == ccu_pkg::FAULT) ||
                              ((state == ccu_pkg::DONE) && cfg.rslt_loaded);
  assign monitor_clear      = in_start;

  assign cfg.state  = state;
  assign cfg.locked = locked;

  assign prog.load    = in_start;
  assign prog.advance = in_operate && rslt_tlast;
  assign prog.total   = cfg.rslt_size;

endmodule

// ==== design/ccu_top.sv ====
`timescale 1ns/10ps

module ccu_top #(
  parameter int DATA_ADDR_W     = 16,
  parameter int GRID_ADDR_W     = 8,
  parameter int SCLE_ADDR_W     = 8,
  parameter int RSLT_CHANNELS   = 4,
  parameter int NUM_PERIPHERALS = 3,
  localparam int PCKT_ADDR_W    = DATA_ADDR_W + GRID_ADDR_W - 1
) (
  input  logic                           fsm_clk,
  input  logic                           rst,
  input  logic                           reg_wr_en,
  input  logic                           reg_rd_en,
  input  logic [ccu_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [ccu_pkg::REG_DATA_W-1:0] reg_wdata,
  output logic [ccu_pkg::REG_DATA_W-1:0] reg_rdata,
  output logic                           reg_rvalid,
  input  logic [NUM_PERIPHERALS-1:0]     peripheral_error,
  input  logic                           rslt_tlast,
  output logic                           operation_start,
  output logic [DATA_ADDR_W:0]           data_size,
  output logic [GRID_ADDR_W:0]           grid_size,
  output logic [SCLE_ADDR_W:0]           scle_size,
  output logic [PCKT_ADDR_W:0]           pckt_size,
  output logic [RSLT_CHANNELS-1:0]       use_channels,
  output logic                           operation_busy,
  output logic                           operation_complete,
  output logic                           operation_error,
  output logic                           locked,
  output logic                           pl2ps_intr
);

  ccu_cfg_if      cfg_i ();
  ccu_progress_if prog_i ();

  logic                       fault;
  logic                       monitor_clear;
  logic [NUM_PERIPHERALS-1:0] fault_mask;

  ccu_reg_file #(
    .NUM_PERIPHERALS (NUM_PERIPHERALS)
  ) reg_file_i (
    .fsm_clk          (fsm_clk),
    .rst              (rst),
    .reg_wr_en        (reg_wr_en),
    .reg_rd_en        (reg_rd_en),
    .reg_addr         (reg_addr),
    .reg_wdata        (reg_wdata),
    .results_exported (prog_i.results_exported),
    .iteration        (prog_i.iteration),
    .fault_mask       (fault_mask),
    .reg_rdata        (reg_rdata),
    .reg_rvalid       (reg_rvalid),
    .cfg              (cfg_i.regs)
  );

  ccu_fsm #(
    .DATA_ADDR_W (DATA_ADDR_W),
    .GRID_ADDR_W (GRID_ADDR_W),
    .SCLE_ADDR_W (SCLE_ADDR_W)
  ) fsm_i (
    .fsm_clk            (fsm_clk),
    .rst                (rst),
    .rslt_tlast         (rslt_tlast),
    .fault              (fault),
    .cfg                (cfg_i.ctrl),
    .prog               (prog_i.ctrl),
    .operation_start    (operation_start),
    .data_size          (data_size),
    .grid_size          (grid_size),
    .scle_size          (scle_size),
    .pckt_size          (pckt_size),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error),
    .locked             (locked),
    .pl2ps_intr         (pl2ps_intr),
    .monitor_clear      (monitor_clear)
  );

  ccu_result_tracker #(
    .RSLT_CHANNELS (RSLT_CHANNELS)
  ) tracker_i (
    .fsm_clk      (fsm_clk),
    .rst          (rst),
    .prog         (prog_i.track),
    .use_channels (use_channels)
  );

  ccu_fault_monitor #(
    .NUM_PERIPHERALS (NUM_PERIPHERALS)
  ) fault_mon_i (
    .fsm_clk          (fsm_clk),
    .rst              (rst),
    .peripheral_error (peripheral_error),
    .clear            (monitor_clear),
    .fault            (fault),
    .fault_mask       (fault_mask)
  );

endmodule

// ==== testbench/ccu_tb_tasks.svh ====
`ifndef CCU_TB_TASKS_SVH
`define CCU_TB_TASKS_SVH

// Random source, 32-bit Fibonacci LFSR with taps 32, 22, 2, 1
logic [31:0] lfsr_state = 32'ha90;

function automatic logic lfsr_next_bit();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = 32'd0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_next_bit()};
  end
  return r;
endfunction

// Expected channel enables for a given number of remaining results
function automatic logic [3:0] channel_mask(input int rem);
  int n;
  n = (rem < 4) ? rem : 4;
  return 4'((32'd1 << n) - 32'd1);
endfunction

// One clock, inputs change 1 ns after the rising edge
task automatic tick();
  @(posedge fsm_clk);
  #1;
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  assert (got === exp) else begin
    report_error($sformatf("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp));
    $fatal(1);
  end
endtask

task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
  reg_wr_en = 1'b1;
  reg_addr  = addr;
  reg_wdata = data;
  tick();
  reg_wr_en = 1'b0;
endtask

// Read data arrives exactly one cycle after the request
task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
  reg_rd_en = 1'b1;
  reg_addr  = addr;
  tick();
  reg_rd_en = 1'b0;
  check_value("reg_rvalid", 32'(reg_rvalid), 32'd1);
  data = reg_rdata;
endtask

`endif

// ==== testbench/ccu_tb.sv ====
`timescale 1ns/10ps

module ccu_tb;

  localparam int CLK_PERIOD  = 4;
  // Cycle budget of all tests together
  localparam int TEST_CYCLES = 20 + 40 + 250 + 60 + 40 + 80;

  logic        fsm_clk;
  logic        rst;
  logic        reg_wr_en;
  logic        reg_rd_en;
  logic [3:0]  reg_addr;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic        reg_rvalid;
  logic [2:0]  peripheral_error;
  logic        rslt_tlast;
  logic        operation_start;
  logic [16:0] data_size;
  logic [8:0]  grid_size;
  logic [8:0]  scle_size;
  logic [23:0] pckt_size;
  logic [3:0]  use_channels;
  logic        operation_busy;
  logic        operation_complete;
  logic        operation_error;
  logic        locked;
  logic        pl2ps_intr;

  logic [31:0] exp_data;
  logic [31:0] exp_grid;
  logic [31:0] exp_scle;
  logic [31:0] exp_pckt;
  logic [31:0] rd;
  int          rslt;
  int          remaining;
  int          tlasts;
  int          starts;
  int          intrs;
  int          fault_bit;
  bit          seen;

  ccu_top dut_i (.*);

  task automatic report_error(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
  endtask

  `include "ccu_tb_tasks.svh"

  initial begin
    fsm_clk = 1'b0;
    forever #(CLK_PERIOD / 2) fsm_clk = ~fsm_clk;
  end

  initial begin
    #(TEST_CYCLES * 2 * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in time");
    $display("FAIL: see errors above");
    $fatal(1);
  end

  // Protocol rules that hold over the whole run
  start_pulse: assert property (@(posedge fsm_clk) disable iff (rst)
    operation_start |=> !operation_start) else begin
    report_error("ERROR operation_start: high for more than one cycle 0x1");
    $fatal(1);
  end

  intr_pulse: assert property (@(posedge fsm_clk) disable iff (rst)
    pl2ps_intr |=> !pl2ps_intr) else begin
    report_error("ERROR pl2ps_intr: high for more than one cycle 0x1");
    $fatal(1);
  end

  sizes_quiet: assert property (@(posedge fsm_clk) disable iff (rst)
    !operation_start |-> ({data_size, grid_size, scle_size, pckt_size} == '0)) else begin
    report_error($sformatf(
      "ERROR data_size grid_size scle_size pckt_size: 0x%0h 0x%0h 0x%0h 0x%0h expected 0x0",
      data_size, grid_size, scle_size, pckt_size));
    $fatal(1);
  end

  // Random valid sizes with the result size and LOADED value from the caller
  task automatic configure(input int rslt_size, input logic [31:0] loaded);
    exp_data = rand_bits(16) + 32'd1;
    exp_grid = rand_bits(8) + 32'd1;
    exp_scle = rand_bits(8) + 32'd1;
    exp_pckt = rand_bits(20) + 32'd1;
    write_reg(ccu_pkg::DATA_SIZE, exp_data);
    write_reg(ccu_pkg::GRID_SIZE, exp_grid);
    write_reg(ccu_pkg::SCLE_SIZE, exp_scle);
    write_reg(ccu_pkg::RSLT_SIZE, 32'(rslt_size));
    write_reg(ccu_pkg::PCKT_SIZE, exp_pckt);
    write_reg(ccu_pkg::LOADED, loaded);
  endtask

  // Start command followed by the START cycle and the move to OPERATE
  task automatic start_run();
    write_reg(ccu_pkg::CONTROL, 32'd1 << ccu_pkg::CTL_START);
    tick();
    check_value("operation_start", 32'(operation_start), 32'd1);
    check_value("data_size", 32'(data_size), exp_data);
    check_value("grid_size", 32'(grid_size), exp_grid);
    check_value("scle_size", 32'(scle_size), exp_scle);
    check_value("pckt_size", 32'(pckt_size), exp_pckt);
    tick();
    check_value("operation_busy", 32'(operation_busy), 32'd1);
  endtask

  task automatic send_tlast();
    rslt_tlast = 1'b1;
    tick();
    rslt_tlast = 1'b0;
  endtask

  task automatic clear_to_idle();
    write_reg(ccu_pkg::CONTROL, 32'd1 << ccu_pkg::CTL_CLEAR);
    tick();
    read_reg(ccu_pkg::STATUS, rd);
    check_value("status idle", 32'(rd[ccu_pkg::ST_IDLE]), 32'd1);
  endtask

  task automatic check_interrupted();
    check_value("operation_busy", 32'(operation_busy), 32'd0);
    check_value("pl2ps_intr", 32'(pl2ps_intr), 32'd1);
    read_reg(ccu_pkg::STATUS, rd);
    check_value("status state", 32'(rd[7:5]), 32'(ccu_pkg::INTERRUPTED));
  endtask

  initial begin
    rst              = 1'b1;
    reg_wr_en        = 1'b0;
    reg_rd_en        = 1'b0;
    reg_addr         = 4'd0;
    reg_wdata        = 32'd0;
    peripheral_error = 3'd0;
    rslt_tlast       = 1'b0;

    // Reset
    for (int c = 0; c < 16; c++) begin
      tick();
      check_value("control outputs in reset", 32'({operation_start, operation_busy,
        operation_complete, operation_error, locked, pl2ps_intr, use_channels}), 32'd0);
    end
    rst = 1'b0;
    tick();
    check_value("control outputs after reset", 32'({operation_start, operation_busy,
      operation_complete, operation_error, locked, pl2ps_intr, use_channels}), 32'd0);
    read_reg(ccu_pkg::STATUS, rd);
    check_value("status idle", 32'(rd[ccu_pkg::ST_IDLE]), 32'd1);
    check_value("status state", 32'(rd[7:5]), 32'(ccu_pkg::IDLE));

    // Invalid start with a missing loaded flag and then an oversized grid
    for (int v = 0; v < 2; v++) begin
      configure(8, (v == 0) ? 32'h17 : 32'h1f);
      if (v == 1) begin
        write_reg(ccu_pkg::GRID_SIZE, 32'd257);
      end
      write_reg(ccu_pkg::CONTROL, 32'd1 << ccu_pkg::CTL_START);
      starts = 0;
      intrs  = 0;
      for (int c = 0; c < 4; c++) begin
        tick();
        starts += int'(operation_start);
        intrs  += int'(pl2ps_intr);
        if (c == 1) begin
          check_value("operation_error", 32'(operation_error), 32'd1);
          check_value("locked", 32'(locked), 32'd1);
        end
      end
      check_value("operation_start count", 32'(starts), 32'd0);
      check_value("pl2ps_intr count", 32'(intrs), 32'd1);
      read_reg(ccu_pkg::STATUS, rd);
      check_value("status error", 32'(rd[ccu_pkg::ST_ERROR]), 32'd1);
      check_value("status locked", 32'(rd[ccu_pkg::ST_LOCKED]), 32'd1);
      check_value("status valid", 32'(rd[ccu_pkg::ST_VALID]), 32'd0);
      clear_to_idle();
    end

    // Full runs with random result sizes
    for (int r = 0; r < 3; r++) begin
      rslt = int'(rand_bits(5) % 32'd20) + 1;
      configure(rslt, 32'h1f);
      start_run();
      read_reg(ccu_pkg::STATUS, rd);
      check_value("status busy", 32'(rd[ccu_pkg::ST_BUSY]), 32'd1);
      check_value("status valid", 32'(rd[ccu_pkg::ST_VALID]), 32'd1);
      remaining = rslt;
      tlasts    = 0;
      while (!operation_complete) begin
        assert (tlasts <= 10) else begin
          report_error("Full run did not complete after the expected number of results");
          $fatal(1);
        end
        repeat (int'(rand_bits(2))) tick();
        check_value("use_channels", 32'(use_channels), 32'(channel_mask(remaining)));
        send_tlast();
        remaining -= (remaining < 4) ? remaining : 4;
        tlasts++;
      end
      check_value("tlast count", 32'(tlasts), 32'((rslt + 3) / 4));
      read_reg(ccu_pkg::PROGRESS_RSLT, rd);
      check_value("progress_rslt", rd, 32'(rslt));
      read_reg(ccu_pkg::PROGRESS_ITER, rd);
      check_value("progress_iter", rd, 32'(tlasts));
      check_value("locked", 32'(locked), 32'd1);
      write_reg(ccu_pkg::LOADED, 32'h0f);
      check_value("locked", 32'(locked), 32'd0);
      tick();
    end

    // Soft interrupt waits for the next result
    configure(20, 32'h1f);
    start_run();
    send_tlast();
    write_reg(ccu_pkg::CONTROL, 32'd1 << ccu_pkg::CTL_SOFT);
    repeat (2) begin
      tick();
      check_value("operation_busy", 32'(operation_busy), 32'd1);
    end
    send_tlast();
    check_interrupted();
    clear_to_idle();

    // Abort
    start_run();
    write_reg(ccu_pkg::CONTROL, 32'd1 << ccu_pkg::CTL_ABORT);
    check_value("operation_busy", 32'(operation_busy), 32'd1);
    tick();
    check_interrupted();
    clear_to_idle();

    // Peripheral fault on a random line
    fault_bit = int'(rand_bits(2) % 32'd3);
    start_run();
    peripheral_error = 3'(32'd1 << fault_bit);
    seen = 1'b0;
    for (int c = 1; c <= 6 && !seen; c++) begin
      tick();
      if (c == 3) begin
        peripheral_error = 3'd0;
      end
      seen = operation_error;
    end
    peripheral_error = 3'd0;
    check_value("operation_error", 32'(operation_error), 32'd1);
    read_reg(ccu_pkg::FAULT_MASK, rd);
    check_value("fault_mask", rd, 32'd1 << fault_bit);
    clear_to_idle();
    start_run();
    read_reg(ccu_pkg::FAULT_MASK, rd);
    check_value("fault_mask", rd, 32'd0);

    // Error command ends the run like an abort
    write_reg(ccu_pkg::CONTROL, 32'd1 << ccu_pkg::CTL_ERROR);
    tick();
    check_interrupted();
    clear_to_idle();

    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+testbench
design/ccu_pkg.sv
design/ccu_cfg_if.sv
design/ccu_progress_if.sv
design/ccu_reg_file.sv
design/ccu_result_tracker.sv
design/ccu_fault_monitor.sv
design/ccu_fsm.sv
design/ccu_top.sv
testbench/ccu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CCU testbench with Verilator, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module ccu_tb \
  -Mdir obj_dir -o ccu_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

(./obj_dir/ccu_sim > sim.log 2>&1 || true) \
  && cat sim.log \
  && grep -qx "PASS: all tests" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
